/* muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

    // one machine word, operand or one half of hi:lo
    typedef logic [31:0] word_t;

    // full product, or the hi:lo pair
    typedef logic [63:0] dword_t;

    // multiplier pipeline depth, inputs to product
    localparam int MUL_LATENCY = 3;

    // start edge to done, 32 steps plus the sign-fix cycle
    localparam int DIV_CYCLES = 33;

    // shift-subtract steps only
    localparam int DIV_STEPS = DIV_CYCLES - 1;

    // controller countdown for the multiply path
    typedef logic [$clog2(MUL_LATENCY + 1)-1:0] mul_cnt_t;

    // divider step counter, counts down to zero
    typedef logic [$clog2(DIV_STEPS)-1:0] div_cnt_t;

    // op strobe from the core, held for one cycle only
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4
    } muldiv_op_t;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MUL  = 2'd1,
        ST_DIV  = 2'd2
    } ctrl_state_t;

    // signed divider result, valid while done is high
    typedef struct packed {
        word_t quotient;
        word_t remainder;
    } div_result_t;

endpackage

`default_nettype wire

/* mul_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_pipe
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  word_t  a,
    input  word_t  b,
    input  logic   is_signed,
    output dword_t product
);

    // stage 1 regs, operands widened to 33 bits
    logic signed [32:0] a_x;
    logic signed [32:0] b_x;

    // b widened to 64 bits, cut into four 16-bit slices
    logic [63:0] b_w;

    // stage 2 regs, one partial product per slice of b
    logic signed [49:0] pp [4];

    // stage 3 input, weighted sum of the partials
    dword_t sum;

    // stage 1
    // sign or zero extension picked by is_signed
    always_ff @(posedge clk) begin
        a_x <= signed'({is_signed & a[31], a});
        b_x <= signed'({is_signed & b[31], b});
    end

    // full 64-bit image of b for slicing
    assign b_w = {{31{b_x[32]}}, b_x};

    // stage 2
    // each slice is unsigned, a carries the sign
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            pp[k] <= a_x * signed'({1'b0, b_w[16*k +: 16]});
        end
    end

    // stage 3 adder
    // slice k weighs 2^(16k), bits above 63 dropped
    always_comb begin
        sum = '0;
        for (int k = 0; k < 4; k++) begin
            sum = sum + ({{14{pp[k][49]}}, pp[k]} << (16 * k));
        end
    end

    // product register
    // valid MUL_LATENCY edges after the operands
    always_ff @(posedge clk) begin
        product <= sum;
    end

endmodule

`default_nettype wire

/* div_iter.sv */
`timescale 1ns/1ps
`default_nettype none

module div_iter
    import muldiv_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    input  logic        is_signed,
    input  word_t       a,
    input  word_t       b,
    output logic        done,
    output div_result_t result
);

    // control state
    logic     busy;
    div_cnt_t cnt;

    // datapath regs
    // partial remainder, dividend shifting out / quotient in
    word_t rem_q;
    word_t quo_q;
    word_t dvs_q;

    // sign of the final quotient and remainder
    logic q_neg;
    logic r_neg;

    // operand signs and magnitudes at start
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;

    // one restoring step
    logic [32:0] trial;
    word_t       rem_step;
    word_t       quo_step;

    // only signed ops see a negative operand
    assign a_neg = is_signed & a[31];
    assign b_neg = is_signed & b[31];

    // most negative value stays 0x80000000, fine as unsigned
    assign a_mag = a_neg ? word_t'(-a) : a;
    assign b_mag = b_neg ? word_t'(-b) : b;

    // shift in next dividend bit, try subtracting divisor
    assign trial = {rem_q, quo_q[31]} - {1'b0, dvs_q};

    // borrow means restore, else keep difference and set q bit
    always_comb begin
        if (trial[32]) begin
            rem_step = {rem_q[30:0], quo_q[31]};
            quo_step = {quo_q[30:0], 1'b0};
        end else begin
            rem_step = trial[31:0];
            quo_step = {quo_q[30:0], 1'b1};
        end
    end

    // step counter and done
    // start edge loads, 32 steps follow, done in the cycle after
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= div_cnt_t'(DIV_STEPS - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                // last step, next cycle is the sign fix
                if (cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dvs_q <= b_mag;
            q_neg <= a_neg ^ b_neg;
            // remainder follows the dividend
            r_neg <= a_neg;
        end else if (busy) begin
            rem_q <= rem_step;
            quo_q <= quo_step;
        end
    end

    // sign fix
    // zero divisor gives all-ones quotient, remainder |a|
    // signs applied the same way so hi ends up equal to a
    assign result.quotient  = q_neg ? word_t'(-quo_q) : quo_q;
    assign result.remainder = r_neg ? word_t'(-rem_q) : rem_q;

endmodule

`default_nettype wire

/* muldiv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl
    import muldiv_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  muldiv_op_t  op,
    input  dword_t      product,
    input  logic        div_done,
    input  div_result_t div_res,
    output logic        mul_signed,
    output logic        div_start,
    output logic        div_signed,
    output word_t       hi,
    output word_t       lo,
    output logic        ok
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // counts down the multiplier pipeline
    mul_cnt_t cnt;
    mul_cnt_t cnt_next;

    // hi:lo write port
    logic   hilo_we;
    dword_t hilo_next;

    // pipeline sees this every cycle, only the issue cycle matters
    assign mul_signed = (op == OP_MULT);

    // divider only started from idle
    assign div_start = (state == ST_IDLE) && (op == OP_DIV || op == OP_DIVU);
    assign div_signed = (op == OP_DIV);

    // idle means hi/lo hold the latest result
    assign ok = (state == ST_IDLE);

    // next state
    always_comb begin
        state_next = state;
        cnt_next   = cnt;
        hilo_we    = 1'b0;
        hilo_next  = product;
        case (state)
            ST_IDLE: begin
                case (op)
                    OP_MULT, OP_MULTU: begin
                        cnt_next   = mul_cnt_t'(MUL_LATENCY);
                        state_next = ST_MUL;
                    end
                    OP_DIV, OP_DIVU: begin
                        state_next = ST_DIV;
                    end
                    default: begin
                        state_next = ST_IDLE;
                    end
                endcase
            end
            ST_MUL: begin
                cnt_next = cnt - 1'b1;
                // our product is on the pipe output now
                if (cnt_next == '0) begin
                    hilo_we    = 1'b1;
                    hilo_next  = product;
                    state_next = ST_IDLE;
                end
            end
            ST_DIV: begin
                // remainder to hi, quotient to lo
                if (div_done) begin
                    hilo_we    = 1'b1;
                    hilo_next  = {div_res.remainder, div_res.quotient};
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // state and counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

    // hi/lo, kept until the next op finishes
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_we) begin
            hi <= hilo_next[63:32];
            lo <= hilo_next[31:0];
        end
    end

endmodule

`default_nettype wire

/* muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
    import muldiv_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  muldiv_op_t op,
    input  word_t      a,
    input  word_t      b,
    output word_t      hi,
    output word_t      lo,
    output logic       ok
);

    // controller to datapath
    logic mul_signed;
    logic div_start;
    logic div_signed;

    // datapath back to controller
    dword_t      product;
    logic        div_done;
    div_result_t div_res;

    // free-running multiplier, samples a and b every cycle
    mul_pipe u_mul (
        .clk       (clk),
        .a         (a),
        .b         (b),
        .is_signed (mul_signed),
        .product   (product)
    );

    // divider latches a and b on div_start
    div_iter u_div (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .is_signed (div_signed),
        .a         (a),
        .b         (b),
        .done      (div_done),
        .result    (div_res)
    );

    // sequencing, hi/lo and ok
    muldiv_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .op         (op),
        .product    (product),
        .div_done   (div_done),
        .div_res    (div_res),
        .mul_signed (mul_signed),
        .div_start  (div_start),
        .div_signed (div_signed),
        .hi         (hi),
        .lo         (lo),
        .ok         (ok)
    );

endmodule

`default_nettype wire

/* muldiv_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit_sva
    import muldiv_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input muldiv_op_t op,
    input logic       ok
);

    // failed assertions so far, the testbench reads this at the end
    int err_cnt = 0;

    // an op counts only while the unit is idle
    logic mul_issue;
    logic div_issue;

    assign mul_issue = ok && (op == OP_MULT || op == OP_MULTU);
    assign div_issue = ok && (op == OP_DIV || op == OP_DIVU);

    // idle once reset has been seen
    a_reset_ok: assert property (@(posedge clk) !resetn |=> ok)
        else begin
            $error("ok is low in the cycle after reset");
            err_cnt++;
        end

    // accepted op, busy from the next edge
    a_issue_busy: assert property (@(posedge clk) disable iff (!resetn)
        (mul_issue || div_issue) |=> !ok)
        else begin
            $error("ok did not fall after an accepted op");
            err_cnt++;
        end

    // multiply back after the pipeline plus the write edge
    a_mul_back: assert property (@(posedge clk) disable iff (!resetn)
        $past(mul_issue, MUL_LATENCY + 1) |-> ok)
        else begin
            $error("ok not back on time after a multiply");
            err_cnt++;
        end

    // divide back after all steps, sign fix and write
    a_div_back: assert property (@(posedge clk) disable iff (!resetn)
        $past(div_issue, DIV_CYCLES + 1) |-> ok)
        else begin
            $error("ok not back on time after a divide");
            err_cnt++;
        end

    // no early return either
    a_no_early: assert property (@(posedge clk) disable iff (!resetn)
        $rose(ok) |-> $past(mul_issue, MUL_LATENCY + 1) || $past(div_issue, DIV_CYCLES + 1))
        else begin
            $error("ok rose at a cycle that matches no issued op");
            err_cnt++;
        end

endmodule

bind muldiv_unit muldiv_unit_sva u_sva (
    .clk    (clk),
    .resetn (resetn),
    .op     (op),
    .ok     (ok)
);

`default_nettype wire

/* tb_muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv_unit
    import muldiv_pkg::*;
();

    // longest wait for ok in cycles
    localparam int TIMEOUT = 100;

    // first cycle with ok high again
    // the issue cycle counts as cycle 0
    localparam int MUL_DONE_CYCLE = 4;
    localparam int DIV_DONE_CYCLE = 34;

    logic       clk = 1'b0;
    logic       resetn;
    muldiv_op_t op;
    word_t      a;
    word_t      b;
    word_t      hi;
    word_t      lo;
    logic       ok;

    int     errors = 0;
    int     timeouts = 0;
    integer seed = 12;

    // edge operands plus a small negative and a small positive value
    word_t corner_vals [7] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                               32'h7fff_ffff, 32'hffff_fff9, 32'd100};

    always #50 clk = ~clk;

    muldiv_unit i_dut (
        .clk    (clk),
        .resetn (resetn),
        .op     (op),
        .a      (a),
        .b      (b),
        .hi     (hi),
        .lo     (lo),
        .ok     (ok)
    );

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // cycles until ok is high
    // gives up after TIMEOUT cycles
    task automatic wait_ok(input string what, output int cycles);
        cycles = 0;
        while (ok !== 1'b1 && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (ok !== 1'b1) begin
            timeouts++;
            $display("timeout: ok stayed low for %0d cycles (%s)", cycles, what);
        end
    endtask

    // expected {hi, lo}
    function automatic dword_t ref_hilo(input muldiv_op_t o, input word_t x, input word_t y);
        longint sx;
        longint sy;
        sx = $signed(x);
        sy = $signed(y);
        case (o)
            OP_MULT:  return dword_t'(sx * sy);
            OP_MULTU: return {32'b0, x} * {32'b0, y};
            OP_DIV: begin
                // zero divisor gives an all-ones magnitude with the usual signs
                if (y == '0) return {x, (x[31] ? 32'd1 : 32'hffff_ffff)};
                return {word_t'(sx % sy), word_t'(sx / sy)};
            end
            OP_DIVU: begin
                if (y == '0) return {x, 32'hffff_ffff};
                return {x % y, x / y};
            end
            default: return '0;
        endcase
    endfunction

    // issue one op and present busy_op in cycle 1
    // then check timing and result
    task automatic run_op(input muldiv_op_t o, input word_t x, input word_t y,
                          input muldiv_op_t busy_op);
        int     waited;
        dword_t exp;
        string  tag;
        tag = $sformatf("%s a=%h b=%h", o.name(), x, y);
        exp = ref_hilo(o, x, y);
        wait_ok("before issue", waited);
        op = o;
        a  = x;
        b  = y;
        step();
        check(ok, 1'b0, {tag, " ok in cycle 1"});
        // other operands that must not reach the result
        op = busy_op;
        a  = ~x;
        b  = y + 32'd7;
        step();
        op = OP_NONE;
        wait_ok(tag, waited);
        if (o == OP_MULT || o == OP_MULTU) begin
            check(2 + waited, MUL_DONE_CYCLE, {tag, " cycle of ok"});
        end else begin
            check(2 + waited, DIV_DONE_CYCLE, {tag, " cycle of ok"});
        end
        check({hi, lo}, exp, {tag, " hi:lo"});
    endtask

    task automatic test_reset();
        resetn = 1'b0;
        repeat (5) step();
        resetn = 1'b1;
        check(ok, 1'b1, "ok after reset");
        check({hi, lo}, 64'h0, "hi:lo after reset");
    endtask

    task automatic test_mul();
        word_t x;
        word_t y;
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) begin
                run_op(OP_MULT, corner_vals[i], corner_vals[j], OP_NONE);
                run_op(OP_MULTU, corner_vals[i], corner_vals[j], OP_NONE);
            end
        end
        repeat (20) begin
            x = $random(seed);
            y = $random(seed);
            run_op(OP_MULT, x, y, OP_NONE);
            x = $random(seed);
            y = $random(seed);
            run_op(OP_MULTU, x, y, OP_NONE);
        end
    endtask

    task automatic test_div();
        word_t x;
        word_t y;
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) begin
                if (corner_vals[j] != '0) begin
                    run_op(OP_DIV, corner_vals[i], corner_vals[j], OP_NONE);
                    run_op(OP_DIVU, corner_vals[i], corner_vals[j], OP_NONE);
                end
            end
        end
        // arithmetic shift gives divisors of mixed size
        repeat (40) begin
            x = $random(seed);
            y = $random(seed);
            y = word_t'($signed(y) >>> x[4:0]);
            if (y == '0) y = 32'd1;
            if (x[5]) begin
                run_op(OP_DIV, x, y, OP_NONE);
            end else begin
                run_op(OP_DIVU, x, y, OP_NONE);
            end
        end
    endtask

    task automatic test_div_zero();
        foreach (corner_vals[i]) begin
            run_op(OP_DIV, corner_vals[i], '0, OP_NONE);
            run_op(OP_DIVU, corner_vals[i], '0, OP_NONE);
        end
    endtask

    // second op while busy is dropped
    task automatic test_busy();
        run_op(OP_MULT, 32'h1234_5678, 32'hfedc_ba98, OP_DIVU);
        run_op(OP_MULTU, 32'hffff_0001, 32'h0003_0005, OP_MULT);
        run_op(OP_DIV, 32'h8765_4321, 32'd13, OP_MULT);
        run_op(OP_DIVU, 32'hf000_0000, 32'd3, OP_DIV);
    endtask

    task automatic test_hold();
        dword_t exp;
        exp = ref_hilo(OP_DIV, 32'hdead_beef, 32'd977);
        run_op(OP_DIV, 32'hdead_beef, 32'd977, OP_NONE);
        repeat (10) begin
            a = $random(seed);
            b = $random(seed);
            step();
            check(ok, 1'b1, "ok while idle");
            check({hi, lo}, exp, "hi:lo held while idle");
        end
    endtask

    initial begin
        op     = OP_NONE;
        a      = '0;
        b      = '0;
        resetn = 1'b0;
        test_reset();
        test_mul();
        test_div();
        test_div_zero();
        test_busy();
        test_hold();
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, i_dut.u_sva.err_cnt);
        if (errors == 0 && timeouts == 0 && i_dut.u_sva.err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* muldiv_unit.f */
muldiv_pkg.sv
mul_pipe.sv
div_iter.sv
muldiv_ctrl.sv
muldiv_unit.sv
muldiv_unit_sva.sv
tb_muldiv_unit.sv

/* Makefile */
TOP = tb_muldiv_unit

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f muldiv_unit.f

# the error limit keeps the run going after a failed assertion
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f muldiv_unit.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
